// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_block_mode
FILELIST = tb.f
BUILD    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(BUILD)

// File: hdl/blk_pkg.sv
/*
 * shared definitions for the block-chaining datapath
 *   word and block types, block count type
 *   chaining mode and direction encodings
 *   block kind tags used between gather and the stages
 */

package blk_pkg;

    // data widths
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int CNT_W           = 16;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the most significant position
    typedef word_t [0:WORDS_PER_BLOCK-1] block_t;

    // number of data blocks minus one
    typedef logic [CNT_W-1:0] cnt_t;

    // chaining mode
    typedef logic [2:0] mode_t;

    localparam mode_t MODE_ECB = 3'h0;
    localparam mode_t MODE_CBC = 3'h1;
    localparam mode_t MODE_CTR = 3'h2;

    // direction
    typedef logic func_t;

    localparam func_t FUNC_ENC = 1'b0;
    localparam func_t FUNC_DEC = 1'b1;

    // role of a gathered block
    typedef logic [1:0] blk_kind_t;

    localparam blk_kind_t KIND_KEY  = 2'h0;
    localparam blk_kind_t KIND_IV   = 2'h1;
    localparam blk_kind_t KIND_DATA = 2'h2;

endpackage

// File: hdl/block_gather.sv
/*
 * block_gather
 *   packs four input words into one block
 *   tags the block with the phase held by the sequencer
 */

`timescale 1ns/10ps

module block_gather (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  blk_pkg::word_t     in_word,
    input  blk_pkg::blk_kind_t cur_kind,
    output logic               gath_valid,
    output blk_pkg::block_t    gath_block,
    output blk_pkg::blk_kind_t gath_kind
);

    localparam int IDX_W = $clog2(blk_pkg::WORDS_PER_BLOCK);

    logic [IDX_W-1:0] word_cnt;
    logic             last_word;

    assign last_word = in_valid && (word_cnt == IDX_W'(blk_pkg::WORDS_PER_BLOCK - 1));

    // word position inside the current block
    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt   <= '0;
            gath_valid <= 1'b0;
        end else begin
            gath_valid <= last_word;
            if (in_valid) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // shift register, word 0 ends up on top
    // stays stable in the gath_valid cycle since the next word lands after it
    always_ff @(posedge clk) begin
        if (in_valid) begin
            gath_block <= {gath_block[1:blk_pkg::WORDS_PER_BLOCK-1], in_word};
        end
        if (last_word) begin
            gath_kind <= cur_kind;
        end
    end

endmodule

// File: hdl/block_mode_top.sv
/*
 * block_mode_top
 *   word stream in, gather, whitening, chaining, scatter, word stream out
 *   run sequencer for phases and completion
 */

`timescale 1ns/10ps

module block_mode_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  blk_pkg::mode_t mode,
    input  blk_pkg::func_t func,
    input  blk_pkg::cnt_t  blocks,
    input  logic           ctr_le,
    input  logic           in_valid,
    input  blk_pkg::word_t in_word,
    output logic           out_valid,
    output blk_pkg::word_t out_word,
    output logic           busy,
    output logic           done
);

    logic               run_start;
    blk_pkg::blk_kind_t cur_kind;
    logic               gath_valid;
    blk_pkg::block_t    gath_block;
    blk_pkg::blk_kind_t gath_kind;
    logic               ciph_valid;
    blk_pkg::block_t    ciph_block;
    blk_pkg::block_t    ciph_data;
    blk_pkg::blk_kind_t ciph_kind;
    blk_pkg::block_t    chain_val;
    logic               res_valid;
    blk_pkg::block_t    res_block;
    logic               blk_sent;

    // stage options only change when no run is open
    assign run_start = start & ~busy;

    block_gather gather_i (
        .clk, .rst, .in_valid, .in_word, .cur_kind,
        .gath_valid, .gath_block, .gath_kind
    );

    block_seq seq_i (
        .clk, .rst, .start, .mode, .blocks, .gath_valid, .blk_sent,
        .cur_kind, .busy, .done
    );

    cipher_stage cipher_i (
        .clk, .rst, .start(run_start), .mode, .func,
        .gath_valid, .gath_block, .gath_kind, .chain_val,
        .ciph_valid, .ciph_block, .ciph_data, .ciph_kind
    );

    chain_stage chain_i (
        .clk, .rst, .start(run_start), .mode, .func, .ctr_le,
        .ciph_valid, .ciph_block, .ciph_data, .ciph_kind,
        .chain_val, .res_valid, .res_block
    );

    block_scatter scatter_i (
        .clk, .rst, .res_valid, .res_block,
        .out_valid, .out_word, .blk_sent
    );

endmodule

// File: hdl/block_scatter.sv
/*
 * block_scatter
 *   holds a result block and sends it as four words, word 0 first
 */

`timescale 1ns/10ps

module block_scatter (
    input  logic            clk,
    input  logic            rst,
    input  logic            res_valid,
    input  blk_pkg::block_t res_block,
    output logic            out_valid,
    output blk_pkg::word_t  out_word,
    output logic            blk_sent
);

    localparam int IDX_W = $clog2(blk_pkg::WORDS_PER_BLOCK);

    blk_pkg::block_t  hold_q;
    logic [IDX_W-1:0] idx;

    // a new block may land in the cycle of the old block's last word
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            idx       <= '0;
        end else if (res_valid) begin
            out_valid <= 1'b1;
            idx       <= '0;
        end else if (out_valid) begin
            idx <= idx + 1'b1;
            if (blk_sent) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            hold_q <= res_block;
        end
    end

    assign out_word = hold_q[idx];
    assign blk_sent = out_valid && (idx == IDX_W'(blk_pkg::WORDS_PER_BLOCK - 1));

endmodule

// File: hdl/block_seq.sv
/*
 * block_seq
 *   run FSM: key, iv, data and drain phases
 *   counts gathered and sent data blocks
 *   drives busy and the done pulse
 */

`timescale 1ns/10ps

module block_seq (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  blk_pkg::mode_t     mode,
    input  blk_pkg::cnt_t      blocks,
    input  logic               gath_valid,
    input  logic               blk_sent,
    output blk_pkg::blk_kind_t cur_kind,
    output logic               busy,
    output logic               done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_KEY,
        ST_IV,
        ST_DATA,
        ST_DRAIN
    } state_t;

    state_t         state;
    blk_pkg::mode_t mode_q;
    blk_pkg::cnt_t  blocks_q;
    blk_pkg::cnt_t  gath_cnt;
    blk_pkg::cnt_t  sent_cnt;
    logic           sent_ok;

    // run options, only taken when a new run opens
    always_ff @(posedge clk) begin
        if (start && (state == ST_IDLE)) begin
            mode_q   <= mode;
            blocks_q <= blocks;
        end
    end

    // results may leave while later blocks are still arriving
    assign sent_ok = blk_sent && ((state == ST_DATA) || (state == ST_DRAIN));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            gath_cnt <= '0;
            sent_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_KEY;
                        gath_cnt <= '0;
                        sent_cnt <= '0;
                    end
                end
                ST_KEY: begin
                    // ECB has no chaining value to load
                    if (gath_valid) begin
                        state <= (mode_q == blk_pkg::MODE_ECB) ? ST_DATA : ST_IV;
                    end
                end
                ST_IV: begin
                    if (gath_valid) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (gath_valid) begin
                        gath_cnt <= gath_cnt + 1'b1;
                        if (gath_cnt == blocks_q) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                default: begin
                end
            endcase

            // last block out closes the run
            if (sent_ok) begin
                sent_cnt <= sent_cnt + 1'b1;
                if (sent_cnt == blocks_q) begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (state)
            ST_KEY:  cur_kind = blk_pkg::KIND_KEY;
            ST_IV:   cur_kind = blk_pkg::KIND_IV;
            default: cur_kind = blk_pkg::KIND_DATA;
        endcase
    end

    assign busy = (state != ST_IDLE);

endmodule

// File: hdl/chain_stage.sv
/*
 * chain_stage
 *   chaining value register, loaded from the IV block
 *   output and update rules per mode, CTR increment
 *   optional byte reversal around the counter increment
 */

`timescale 1ns/10ps

module chain_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  blk_pkg::mode_t     mode,
    input  blk_pkg::func_t     func,
    input  logic               ctr_le,
    input  logic               ciph_valid,
    input  blk_pkg::block_t    ciph_block,
    input  blk_pkg::block_t    ciph_data,
    input  blk_pkg::blk_kind_t ciph_kind,
    output blk_pkg::block_t    chain_val,
    output logic               res_valid,
    output blk_pkg::block_t    res_block
);

    blk_pkg::mode_t  mode_q;
    blk_pkg::func_t  func_q;
    logic            le_q;
    blk_pkg::block_t res_next;
    blk_pkg::block_t chain_next;

    function automatic blk_pkg::word_t bswap(input blk_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // only word 3 counts, wraps at 2^32
    function automatic blk_pkg::block_t ctr_inc(input blk_pkg::block_t c, input logic le);
        blk_pkg::block_t r;
        blk_pkg::word_t  w;
        r    = c;
        w    = le ? bswap(c[3]) : c[3];
        w    = w + 1'b1;
        r[3] = le ? bswap(w) : w;
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q    <= blk_pkg::MODE_ECB;
            func_q    <= blk_pkg::FUNC_ENC;
            le_q      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (start) begin
                mode_q <= mode;
                func_q <= func;
                le_q   <= ctr_le;
            end
            res_valid <= ciph_valid && (ciph_kind == blk_pkg::KIND_DATA);
        end
    end

    always_comb begin
        res_next   = ciph_block;
        chain_next = chain_val;
        case (mode_q)
            blk_pkg::MODE_CBC: begin
                if (func_q == blk_pkg::FUNC_ENC) begin
                    chain_next = ciph_block;
                end else begin
                    res_next   = ciph_block ^ chain_val;
                    chain_next = ciph_data;
                end
            end
            blk_pkg::MODE_CTR: begin
                res_next   = ciph_data ^ ciph_block;
                chain_next = ctr_inc(chain_val, le_q);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ciph_valid) begin
            if (ciph_kind == blk_pkg::KIND_IV) begin
                chain_val <= ciph_block;
            end else begin
                chain_val <= chain_next;
            end
            res_block <= res_next;
        end
    end

endmodule

// File: hdl/cipher_stage.sv
/*
 * cipher_stage
 *   key register
 *   forms the cipher input per mode and whitens it with the key
 */

`timescale 1ns/10ps

module cipher_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  blk_pkg::mode_t     mode,
    input  blk_pkg::func_t     func,
    input  logic               gath_valid,
    input  blk_pkg::block_t    gath_block,
    input  blk_pkg::blk_kind_t gath_kind,
    input  blk_pkg::block_t    chain_val,
    output logic               ciph_valid,
    output blk_pkg::block_t    ciph_block,
    output blk_pkg::block_t    ciph_data,
    output blk_pkg::blk_kind_t ciph_kind
);

    blk_pkg::mode_t  mode_q;
    blk_pkg::func_t  func_q;
    blk_pkg::block_t key_q;
    blk_pkg::block_t cipher_in;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q     <= blk_pkg::MODE_ECB;
            func_q     <= blk_pkg::FUNC_ENC;
            ciph_valid <= 1'b0;
        end else begin
            if (start) begin
                mode_q <= mode;
                func_q <= func;
            end
            // key blocks stop here
            ciph_valid <= gath_valid && (gath_kind != blk_pkg::KIND_KEY);
        end
    end

    // CBC encrypt folds C in before whitening, CTR whitens the counter itself
    always_comb begin
        case (mode_q)
            blk_pkg::MODE_CBC:
                cipher_in = (func_q == blk_pkg::FUNC_ENC) ? (gath_block ^ chain_val) : gath_block;
            blk_pkg::MODE_CTR:
                cipher_in = chain_val;
            default:
                cipher_in = gath_block;
        endcase
    end

    always_ff @(posedge clk) begin
        if (gath_valid) begin
            if (gath_kind == blk_pkg::KIND_KEY) begin
                key_q <= gath_block;
            end
            ciph_kind <= gath_kind;
            ciph_data <= gath_block;
            // IV goes through untouched
            ciph_block <= (gath_kind == blk_pkg::KIND_IV) ? gath_block : (cipher_in ^ key_q);
        end
    end

endmodule

// File: tb.f
+incdir+tests
hdl/blk_pkg.sv
hdl/block_gather.sv
hdl/block_seq.sv
hdl/cipher_stage.sv
hdl/chain_stage.sv
hdl/block_scatter.sv
hdl/block_mode_top.sv
tests/tb_block_mode.sv

// File: tests/tb_tests.svh
/*
 * stimulus drivers and directed tests for block_mode_top
 *   ECB with latency, CBC round trip, CTR wrap in both byte orders
 *   input gaps against back-to-back, busy and done with a stray start
 */

function automatic blk_pkg::block_t rand_block();
    blk_pkg::block_t b;
    for (int k = 0; k < blk_pkg::WORDS_PER_BLOCK; k++) begin
        b[k] = $urandom();
    end
    return b;
endfunction

task automatic fill_data(input int n);
    data_q.delete();
    repeat (n) begin
        data_q.push_back(rand_block());
    end
endtask

task automatic open_run(input blk_pkg::mode_t m, input blk_pkg::func_t f, input logic le,
                        input int nblk);
    check_flag("busy", busy, 1'b0);
    mode   = m;
    func   = f;
    ctr_le = le;
    blocks = blk_pkg::cnt_t'(nblk - 1);
    start  = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_flag("busy", busy, 1'b1);
    in_run = 1'b1;
endtask

// mark records the cycle of a data block's fourth word
task automatic send_word(input blk_pkg::word_t w, input int gap, input logic mark);
    repeat (gap) @(negedge clk);
    in_valid = 1'b1;
    in_word  = w;
    if (mark) begin
        last_in_q.push_back(cyc);
    end
    @(negedge clk);
    in_valid = 1'b0;
endtask

task automatic send_block(input blk_pkg::block_t b, input int gap_max, input logic is_data);
    for (int k = 0; k < blk_pkg::WORDS_PER_BLOCK; k++) begin
        send_word(b[k], $urandom_range(gap_max, 0), is_data && (k == 3));
    end
endtask

task automatic wait_done();
    while (!done) begin
        @(negedge clk);
    end
    in_run = 1'b0;
endtask

task automatic run_case(input blk_pkg::mode_t m, input blk_pkg::func_t f, input logic le,
                        input blk_pkg::block_t key, input blk_pkg::block_t iv,
                        input int gap_max);
    model_run(m, f, le, key, iv);
    open_run(m, f, le, data_q.size());
    send_block(key, gap_max, 1'b0);
    if (m != blk_pkg::MODE_ECB) begin
        send_block(iv, gap_max, 1'b0);
    end
    foreach (data_q[i]) begin
        send_block(data_q[i], gap_max, 1'b1);
    end
    wait_done();
endtask

task automatic ecb_after_reset();
    blk_pkg::block_t key;
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    key = rand_block();
    fill_data(3);
    run_case(blk_pkg::MODE_ECB, blk_pkg::FUNC_ENC, 1'b0, key, key, 0);
endtask

task automatic cbc_round_trip();
    blk_pkg::block_t key;
    blk_pkg::block_t iv;
    blk_pkg::block_t plain[$];
    key = rand_block();
    iv  = rand_block();
    fill_data(4);
    plain = data_q;
    run_case(blk_pkg::MODE_CBC, blk_pkg::FUNC_ENC, 1'b0, key, iv, 2);
    data_q = model_q;
    got_q.delete();
    run_case(blk_pkg::MODE_CBC, blk_pkg::FUNC_DEC, 1'b0, key, iv, 2);
    if (got_q.size() != plain.size() * blk_pkg::WORDS_PER_BLOCK) begin
        err_other++;
        $display("CBC decrypt gave %0d words instead of the plaintext length", got_q.size());
    end else begin
        foreach (plain[i]) begin
            for (int k = 0; k < blk_pkg::WORDS_PER_BLOCK; k++) begin
                check_word("out_word", got_q[i * blk_pkg::WORDS_PER_BLOCK + k], plain[i][k]);
            end
        end
    end
endtask

// all ones in word 3 wraps on the first increment in either byte order
task automatic ctr_wrap_both_orders();
    blk_pkg::block_t key;
    blk_pkg::block_t ctr0;
    key     = rand_block();
    ctr0    = rand_block();
    ctr0[3] = 32'hffff_ffff;
    fill_data(3);
    run_case(blk_pkg::MODE_CTR, blk_pkg::FUNC_ENC, 1'b0, key, ctr0, 1);
    fill_data(3);
    run_case(blk_pkg::MODE_CTR, blk_pkg::FUNC_DEC, 1'b1, key, ctr0, 1);
endtask

task automatic gap_invariance();
    blk_pkg::block_t key;
    blk_pkg::block_t iv;
    blk_pkg::word_t  tight_q[$];
    key = rand_block();
    iv  = rand_block();
    fill_data(4);
    got_q.delete();
    // back-to-back keeps two blocks in flight
    run_case(blk_pkg::MODE_CBC, blk_pkg::FUNC_ENC, 1'b0, key, iv, 0);
    tight_q = got_q;
    got_q.delete();
    run_case(blk_pkg::MODE_CBC, blk_pkg::FUNC_ENC, 1'b0, key, iv, 5);
    if (got_q.size() != tight_q.size()) begin
        err_other++;
        $display("gapped input gave %0d words, back-to-back gave %0d",
                 got_q.size(), tight_q.size());
    end else begin
        foreach (tight_q[i]) begin
            check_word("out_word", got_q[i], tight_q[i]);
        end
    end
endtask

task automatic start_while_busy();
    blk_pkg::block_t key;
    key = rand_block();
    fill_data(2);
    model_run(blk_pkg::MODE_ECB, blk_pkg::FUNC_ENC, 1'b0, key, key);
    open_run(blk_pkg::MODE_ECB, blk_pkg::FUNC_ENC, 1'b0, 2);
    send_block(key, 0, 1'b0);
    send_block(data_q[0], 0, 1'b1);
    // a new start with other options, the open run must not notice it
    mode   = blk_pkg::MODE_CTR;
    blocks = '0;
    start  = 1'b1;
    @(negedge clk);
    start = 1'b0;
    send_block(data_q[1], 1, 1'b1);
    wait_done();
    repeat (12) @(negedge clk);
    check_flag("busy", busy, 1'b0);
endtask

// File: tests/tb_block_mode.sv
/*
 * testbench for block_mode_top
 *   clock, reset, DUT instance, output monitor
 *   reference model of the chaining table, compare tasks
 *   cycle limit and closing summary
 */

`timescale 1ns/10ps

module tb_block_mode;

    localparam int DATA_BLOCKS = 27;
    localparam int CYCLE_LIMIT = 200 * DATA_BLOCKS + 2000;
    localparam int LATENCY     = 4;

    logic           clk;
    logic           rst;
    logic           start;
    blk_pkg::mode_t mode;
    blk_pkg::func_t func;
    blk_pkg::cnt_t  blocks;
    logic           ctr_le;
    logic           in_valid;
    blk_pkg::word_t in_word;
    logic           out_valid;
    blk_pkg::word_t out_word;
    logic           busy;
    logic           done;

    int   cyc;
    int   err_word;
    int   err_flag;
    int   err_lat;
    int   err_other;
    int   words_out;
    logic in_run;
    logic done_exp;

    blk_pkg::word_t  exp_q[$];
    blk_pkg::word_t  got_q[$];
    int              last_in_q[$];
    blk_pkg::block_t data_q[$];
    blk_pkg::block_t model_q[$];

    block_mode_top dut_i (
        .clk, .rst, .start, .mode, .func, .blocks, .ctr_le,
        .in_valid, .in_word, .out_valid, .out_word, .busy, .done
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("timeout: the run was still open after %0d cycles", cyc);
        $display("Regression failed");
        $finish;
    end

    task automatic check_word(input string name, input blk_pkg::word_t got,
                              input blk_pkg::word_t exp);
        if (got !== exp) begin
            err_word++;
            $display("mismatch %s got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_flag++;
            $display("mismatch %s got %h expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_latency(input int got);
        if (got != LATENCY) begin
            err_lat++;
            $display("first result word came %0d cycles after the last input word, not %0d",
                     got, LATENCY);
        end
    endtask

    function automatic blk_pkg::word_t byte_rev(input blk_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // expected results for the blocks in data_q
    // w holds the whitened cipher input
    task automatic model_run(input blk_pkg::mode_t m, input blk_pkg::func_t f, input logic le,
                             input blk_pkg::block_t key, input blk_pkg::block_t iv);
        blk_pkg::block_t c;
        blk_pkg::block_t w;
        blk_pkg::block_t r;
        blk_pkg::word_t  ctr;
        c = iv;
        model_q.delete();
        foreach (data_q[i]) begin
            if (m == blk_pkg::MODE_CTR) begin
                w    = c ^ key;
                r    = data_q[i] ^ w;
                ctr  = le ? byte_rev(c[3]) : c[3];
                ctr  = ctr + 32'd1;
                c[3] = le ? byte_rev(ctr) : ctr;
            end else if (m == blk_pkg::MODE_CBC && f == blk_pkg::FUNC_ENC) begin
                w = data_q[i] ^ c ^ key;
                r = w;
                c = w;
            end else if (m == blk_pkg::MODE_CBC) begin
                w = data_q[i] ^ key;
                r = w ^ c;
                c = data_q[i];
            end else begin
                r = data_q[i] ^ key;
            end
            model_q.push_back(r);
            for (int k = 0; k < blk_pkg::WORDS_PER_BLOCK; k++) begin
                exp_q.push_back(r[k]);
            end
        end
    endtask

    // registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_flag("done", done, done_exp);
            if (in_run) begin
                check_flag("busy", busy, !done_exp);
            end
            done_exp = 1'b0;
            if (out_valid) begin
                got_q.push_back(out_word);
                if (words_out % blk_pkg::WORDS_PER_BLOCK == 0) begin
                    if (last_in_q.size() == 0) begin
                        err_other++;
                        $display("result block appeared before its input block was sent");
                    end else begin
                        check_latency(cyc - last_in_q.pop_front());
                    end
                end
                words_out++;
                if (exp_q.size() == 0) begin
                    err_other++;
                    $display("output word %h appeared with no word expected", out_word);
                end else begin
                    check_word("out_word", out_word, exp_q.pop_front());
                    // done follows the last word of the run by one cycle
                    done_exp = (exp_q.size() == 0);
                end
            end
        end
    end

    `include "tb_tests.svh"

    initial begin
        void'($urandom(91));
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        mode     = blk_pkg::MODE_ECB;
        func     = blk_pkg::FUNC_ENC;
        blocks   = '0;
        ctr_le   = 1'b0;
        in_valid = 1'b0;
        in_word  = '0;
        in_run   = 1'b0;
        done_exp = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        ecb_after_reset();
        cbc_round_trip();
        ctr_wrap_both_orders();
        gap_invariance();
        start_while_busy();

        if (exp_q.size() != 0 || last_in_q.size() != 0) begin
            err_other++;
            $display("%0d expected words never came out", exp_q.size());
        end
        $display("errors: word %0d flag %0d latency %0d other %0d",
                 err_word, err_flag, err_lat, err_other);
        if (err_word + err_flag + err_lat + err_other == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
